// File: conv_pkg.sv
`default_nettype none

package conv_pkg;

	localparam int PIX_W   = 8;
	localparam int ROW_PIX = 8;
	localparam int ROW_W   = PIX_W * ROW_PIX;
	localparam int KSIZE   = 3;
	localparam int TAPS    = KSIZE * KSIZE;
	localparam int PROD_W  = 2 * PIX_W;
	localparam int SUM_W   = 20; // Nine full-scale products fit below 2^20

	typedef logic [PIX_W-1:0]         pix_t;
	typedef logic [ROW_W-1:0]         row_t;    // Pixel p in bits 8p+7:8p
	typedef logic [KSIZE*ROW_W-1:0]   window_t; // Row 0 oldest, row 2 newest
	typedef logic [TAPS*PIX_W-1:0]    weight_t; // Tap r*3+c in byte r*3+c
	typedef logic [PROD_W-1:0]        prod_t;
	typedef logic [SUM_W-1:0]         sum_t;
	typedef logic [1:0]               ctrl_t;

	localparam ctrl_t CTRL_END   = 2'd0;
	localparam ctrl_t CTRL_START = 2'd1;
	localparam ctrl_t CTRL_HOLD  = 2'd2;

endpackage

`default_nettype wire

// File: row_window.sv
`timescale 1ns/1ps
`default_nettype none

module row_window
	import conv_pkg::*;
(
	input  wire     clk,
	input  wire     rst,
	input  wire row_t i_row,
	input  wire     i_row_valid,
	input  wire     i_pad,
	output window_t o_window
);

	window_t win;
	row_t    new_row;

	assign new_row = i_row_valid ? i_row : '0; // Padding shifts in a zero row

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			win <= '0;
		end else if (i_row_valid || i_pad) begin
			win <= {new_row, win[KSIZE*ROW_W-1:ROW_W]}; // Oldest row drops out
		end
	end

	assign o_window = win;

endmodule

`default_nettype wire

// File: weight_loader.sv
`timescale 1ns/1ps
`default_nettype none

module weight_loader
	import conv_pkg::*;
(
	input  wire       clk,
	input  wire       rst,
	input  wire row_t i_w_data,
	input  wire       i_w_valid,
	input  wire       i_reload,
	output weight_t   o_weight
);

	weight_t weight;
	logic    word_cnt; // 0 expects taps 0-7, 1 expects tap 8
	logic    full;
	logic    cnt_eff;
	logic    full_eff;

	// A word that arrives with the reload pulse counts as the first word
	assign cnt_eff  = i_reload ? 1'b0 : word_cnt;
	assign full_eff = i_reload ? 1'b0 : full;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			weight   <= '0;
			word_cnt <= 1'b0;
			full     <= 1'b0;
		end else if (i_w_valid && !full_eff) begin
			if (!cnt_eff) begin
				weight[8*PIX_W-1:0] <= i_w_data; // Taps 0-7
				word_cnt            <= 1'b1;
				full                <= 1'b0;
			end else begin
				weight[TAPS*PIX_W-1 -: PIX_W] <= i_w_data[PIX_W-1:0]; // Tap 8
				full                          <= 1'b1;
			end
		end else if (i_reload) begin
			word_cnt <= 1'b0; // Weights kept, loading rearmed
			full     <= 1'b0;
		end
	end

	assign o_weight = weight;

endmodule

`default_nettype wire

// File: conv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl
	import conv_pkg::*;
(
	input  wire        clk,
	input  wire        rst,
	input  wire ctrl_t i_ctrl,
	output logic       o_res_valid,
	output logic       o_finish,
	output logic       o_reload
);

	typedef enum logic [1:0] {
		ST_WAIT,
		ST_COMPUTE,
		ST_FINISH
	} state_t;

	state_t state;
	state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_WAIT: begin
				if (i_ctrl == CTRL_START) state_nxt = ST_COMPUTE;
				else if (i_ctrl == CTRL_END) state_nxt = ST_FINISH;
			end
			ST_COMPUTE: begin
				if (i_ctrl == CTRL_HOLD) state_nxt = ST_WAIT;
				else if (i_ctrl == CTRL_END) state_nxt = ST_FINISH;
			end
			default: state_nxt = ST_FINISH; // Held until reset
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state    <= ST_WAIT;
			o_reload <= 1'b0;
		end else begin
			state    <= state_nxt;
			o_reload <= (i_ctrl == CTRL_HOLD) && (state != ST_FINISH);
		end
	end

	assign o_res_valid = (state == ST_COMPUTE);
	assign o_finish    = (state == ST_FINISH);

endmodule

`default_nettype wire

// File: pe_cube.sv
`timescale 1ns/1ps
`default_nettype none

module pe_cube
	import conv_pkg::*;
#(
	parameter int CUBE_IDX = 0
) (
	input  wire          clk,
	input  wire          rst,
	input  wire window_t i_window,
	input  wire weight_t i_weight,
	input  wire          i_stride,
	output logic [TAPS*PROD_W-1:0] o_prod
);

	pix_t  pix [TAPS];
	prod_t prod [TAPS];

	// Column c of cube k reads pixel (k*S + c) mod 8, wrapping past the row end
	always_comb begin
		int col;
		for (int r = 0; r < KSIZE; r++) begin
			for (int c = 0; c < KSIZE; c++) begin
				col = (i_stride ? 2 * CUBE_IDX : CUBE_IDX) + c;
				col = col % ROW_PIX;
				pix[r*KSIZE+c] = i_window[ROW_W*r + PIX_W*col +: PIX_W];
			end
		end
	end

	always_comb begin
		for (int t = 0; t < TAPS; t++) begin
			prod[t] = i_weight[t*PIX_W +: PIX_W] * pix[t]; // Unsigned 8x8
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_prod <= '0;
		end else begin
			for (int t = 0; t < TAPS; t++) begin
				o_prod[t*PROD_W +: PROD_W] <= prod[t];
			end
		end
	end

endmodule

`default_nettype wire

// File: result_reduce.sv
`timescale 1ns/1ps
`default_nettype none

module result_reduce
	import conv_pkg::*;
#(
	parameter int NUM_CUBE = 8
) (
	input  wire                             clk,
	input  wire                             rst,
	input  wire [NUM_CUBE*TAPS*PROD_W-1:0]  i_prod,
	output logic [NUM_CUBE*SUM_W-1:0]       o_result
);

	sum_t sums [NUM_CUBE];

	// Per cube: three row partials, then their total
	always_comb begin
		sum_t part [KSIZE];
		for (int k = 0; k < NUM_CUBE; k++) begin
			for (int r = 0; r < KSIZE; r++) begin
				part[r] = sum_t'(i_prod[(k*TAPS + r*KSIZE)*PROD_W +: PROD_W])
					+ sum_t'(i_prod[(k*TAPS + r*KSIZE + 1)*PROD_W +: PROD_W])
					+ sum_t'(i_prod[(k*TAPS + r*KSIZE + 2)*PROD_W +: PROD_W]);
			end
			sums[k] = part[0] + part[1] + part[2];
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_result <= '0;
		end else begin
			for (int k = 0; k < NUM_CUBE; k++) begin
				o_result[k*SUM_W +: SUM_W] <= sums[k];
			end
		end
	end

endmodule

`default_nettype wire

// File: conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_top
	import conv_pkg::*;
#(
	parameter int NUM_CUBE = 8 // 1 to 16
) (
	input  wire                        clk,
	input  wire                        rst,
	input  wire ctrl_t                 i_ctrl,
	input  wire row_t                  i_row,
	input  wire                        i_row_valid,
	input  wire                        i_pad,
	input  wire                        i_stride,
	input  wire row_t                  i_w_data,
	input  wire                        i_w_valid,
	output logic [NUM_CUBE*SUM_W-1:0]  o_result,
	output logic                       o_res_valid,
	output logic                       o_finish
);

	window_t                      window;
	weight_t                      weight;
	logic                         reload;
	logic [NUM_CUBE*TAPS*PROD_W-1:0] prod_bus;

	row_window u_row_window (
		.clk         (clk),
		.rst         (rst),
		.i_row       (i_row),
		.i_row_valid (i_row_valid),
		.i_pad       (i_pad),
		.o_window    (window)
	);

	weight_loader u_weight_loader (
		.clk       (clk),
		.rst       (rst),
		.i_w_data  (i_w_data),
		.i_w_valid (i_w_valid),
		.i_reload  (reload),
		.o_weight  (weight)
	);

	conv_ctrl u_conv_ctrl (
		.clk         (clk),
		.rst         (rst),
		.i_ctrl      (i_ctrl),
		.o_res_valid (o_res_valid),
		.o_finish    (o_finish),
		.o_reload    (reload)
	);

	for (genvar k = 0; k < NUM_CUBE; k++) begin : g_cube
		pe_cube #(
			.CUBE_IDX (k)
		) u_pe_cube (
			.clk      (clk),
			.rst      (rst),
			.i_window (window),
			.i_weight (weight),
			.i_stride (i_stride),
			.o_prod   (prod_bus[k*TAPS*PROD_W +: TAPS*PROD_W])
		);
	end

	result_reduce #(
		.NUM_CUBE (NUM_CUBE)
	) u_result_reduce (
		.clk      (clk),
		.rst      (rst),
		.i_prod   (prod_bus),
		.o_result (o_result)
	);

endmodule

`default_nettype wire

// File: tb_conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conv_top
	import conv_pkg::*;
();

	localparam int    NUM_CUBE  = 8;
	localparam int    N_RAND    = 8;
	localparam ctrl_t CTRL_NONE = 2'd3; // No command, state and loader stay put

	logic                      clk;
	logic                      rst;
	ctrl_t                     i_ctrl;
	row_t                      i_row;
	logic                      i_row_valid;
	logic                      i_pad;
	logic                      i_stride;
	row_t                      i_w_data;
	logic                      i_w_valid;
	logic [NUM_CUBE*SUM_W-1:0] o_result;
	logic                      o_res_valid;
	logic                      o_finish;

	row_t cur_rows [3]; // Expected window, row 0 oldest
	row_t cur_w0;
	row_t cur_w1;
	logic cur_s;
	int   errors      = 0;
	int   checks      = 0;
	int   cycles      = 0;
	int   cycle_limit = 12 * N_RAND + 50; // Each case from the file adds 12 more

	conv_top #(
		.NUM_CUBE (NUM_CUBE)
	) DUT (
		.clk         (clk),
		.rst         (rst),
		.i_ctrl      (i_ctrl),
		.i_row       (i_row),
		.i_row_valid (i_row_valid),
		.i_pad       (i_pad),
		.i_stride    (i_stride),
		.i_w_data    (i_w_data),
		.i_w_valid   (i_w_valid),
		.o_result    (o_result),
		.o_res_valid (o_res_valid),
		.o_finish    (o_finish)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: run still busy after %0d cycles", cycle_limit);
			$display("TEST FAIL");
			$finish;
		end
	end

	// Cube k: sum of weight[r*3+c] * pixel ((k*S + c) mod 8) of row r
	function automatic sum_t ref_sum(input int k);
		pix_t wt;
		pix_t px;
		int   col;
		sum_t acc;
		acc = '0;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				wt  = (r*3 + c < 8) ? cur_w0[8*(r*3 + c) +: 8] : cur_w1[7:0]; // Tap 8 from word two
				col = ((cur_s ? 2 * k : k) + c) % 8;
				px  = cur_rows[r][8*col +: 8];
				acc += sum_t'(wt) * sum_t'(px);
			end
		end
		return acc;
	endfunction

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp) else begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_result(input string what);
		sum_t got;
		sum_t exp;
		for (int k = 0; k < NUM_CUBE; k++) begin
			got = o_result[k*SUM_W +: SUM_W];
			exp = ref_sum(k);
			checks++;
			assert (got === exp) else begin
				$display("[ERROR] %s o_result cube %0d: got %h, expected %h", what, k, got, exp);
				errors++;
			end
		end
	endtask

	task automatic shift_model(input row_t r);
		cur_rows[0] = cur_rows[1];
		cur_rows[1] = cur_rows[2];
		cur_rows[2] = r;
	endtask

	task automatic settle();
		while (!o_res_valid) @(negedge clk);
		repeat (2) @(negedge clk); // Product stage, then sum stage
	endtask

	// Called on a falling edge: reload weights in WAIT, push three rows, restart
	task automatic run_case(input logic s, input row_t rows [3], input row_t w0,
			input row_t w1, input string what);
		i_ctrl = CTRL_HOLD;
		@(negedge clk);
		i_ctrl = CTRL_NONE;
		check_flag("o_res_valid in WAIT", o_res_valid, 1'b0);
		i_w_valid = 1'b1;
		i_w_data  = w0;
		@(negedge clk);
		i_w_data = w1;
		@(negedge clk);
		i_w_data = ~w0; // Third word must be dropped
		@(negedge clk);
		i_w_valid = 1'b0;
		i_stride  = s;
		cur_w0    = w0;
		cur_w1    = w1;
		cur_s     = s;
		for (int j = 0; j < 3; j++) begin
			i_row_valid = 1'b1;
			i_row       = rows[j];
			shift_model(rows[j]);
			if (j == 2) i_ctrl = CTRL_START;
			@(negedge clk);
		end
		i_row_valid = 1'b0;
		settle();
		check_result(what);
	endtask

	initial begin
		int          fd;
		int          n;
		int          n_file;
		string       line;
		logic [31:0] s;
		logic [31:0] e [NUM_CUBE];
		row_t        rr [3];
		row_t        rw0;
		row_t        rw1;
		sum_t        model;
		ctrl_t       later [3];
		rst         = 1'b0;
		i_ctrl      = CTRL_NONE;
		i_row       = '0;
		i_row_valid = 1'b0;
		i_pad       = 1'b0;
		i_stride    = 1'b0;
		i_w_data    = '0;
		i_w_valid   = 1'b0;
		for (int j = 0; j < 3; j++) begin
			cur_rows[j] = '0;
		end
		cur_w0   = '0;
		cur_w1   = '0;
		cur_s    = 1'b0;
		n_file   = 0;
		later[0] = CTRL_START;
		later[1] = CTRL_HOLD;
		later[2] = CTRL_NONE;
		s = $urandom(32'h583d_1428);
		repeat (2) @(negedge clk);
		rst = 1'b1;
		check_flag("o_res_valid after reset", o_res_valid, 1'b0);
		check_flag("o_finish after reset", o_finish, 1'b0);
		check_result("after reset");
		i_ctrl = CTRL_START;
		@(negedge clk);
		check_flag("o_res_valid after START", o_res_valid, 1'b1);

		fd = $fopen("conv_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open conv_cases.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#") continue;
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h", s,
					rr[0], rr[1], rr[2], rw0, rw1, e[0], e[1], e[2], e[3], e[4], e[5], e[6], e[7]);
				if (n != 14) begin
					$display("Malformed line in conv_cases.txt: %s", line);
					errors++;
					continue;
				end
				cycle_limit += 12;
				n_file++;
				run_case(s[0], rr, rw0, rw1, $sformatf("file case %0d", n_file));
				for (int k = 0; k < NUM_CUBE; k++) begin
					model = ref_sum(k);
					checks++;
					assert (model == e[k]) else begin
						$display("[ERROR] conv_cases.txt case %0d sum cube %0d: file %h, rule %h",
							n_file, k, e[k], model);
						errors++;
					end
				end
			end
			$fclose(fd);
		end

		for (int i = 0; i < N_RAND; i++) begin
			for (int j = 0; j < 3; j++) begin
				rr[j] = {$urandom(), $urandom()};
			end
			rw0 = {$urandom(), $urandom()};
			rw1 = {$urandom(), $urandom()};
			s   = $urandom();
			run_case(s[0], rr, rw0, rw1, $sformatf("random case %0d", i));
		end

		// Zero rows enter at the newest end
		for (int p = 0; p < 3; p++) begin
			i_pad = 1'b1;
			shift_model('0);
			@(negedge clk);
			i_pad = 1'b0;
			settle();
			if (p == 0) check_result("one pad");
		end
		check_result("three pads");

		i_ctrl = CTRL_END;
		@(negedge clk);
		check_flag("o_finish after END", o_finish, 1'b1);
		check_flag("o_res_valid after END", o_res_valid, 1'b0);
		for (int j = 0; j < 3; j++) begin
			i_ctrl = later[j];
			@(negedge clk);
			check_flag("o_finish held", o_finish, 1'b1);
			check_flag("o_res_valid held low", o_res_valid, 1'b0);
		end

		$display("Done: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: conv_cases.txt
# stride row0(oldest) row1 row2(newest) wword0(taps0-7) wword1(tap8 in byte0)
# then expected sums of cubes 0..7; all fields hex
0 0101010101010101 0101010101010101 0101010101010101 0101010101010101 0000000000000001 9 9 9 9 9 9 9 9
1 0101010101010101 0101010101010101 0101010101010101 0101010101010101 0000000000000001 9 9 9 9 9 9 9 9
0 0706050403020100 0706050403020100 0706050403020100 0101010101010101 0000000000000001 9 12 1b 24 2d 36 27 18
1 0706050403020100 0706050403020100 0706050403020100 0101010101010101 0000000000000001 9 1b 2d 27 9 1b 2d 27
0 ffffffffffffffff ffffffffffffffff f0e0d0c0b0a09080 0000000000000000 ffffffffffffff02 140 160 180 1a0 1c0 1e0 100 120
1 ffffffffffffffff ffffffffffffffff f0e0d0c0b0a09080 0000000000000000 ffffffffffffff02 140 180 1c0 100 140 180 1c0 100
0 0706050403020100 ffffffffffffffff ffffffffffffffff 0000000000000001 ffffffffffffff00 0 1 2 3 4 5 6 7
1 0706050403020100 ffffffffffffffff ffffffffffffffff 0000000000000001 ffffffffffffff00 0 2 4 6 0 2 4 6
0 0101010101010101 0202020202020202 0303030303030303 0807060504030201 0000000000000009 6c 6c 6c 6c 6c 6c 6c 6c
1 ffffffffffffffff ffffffffffffffff ffffffffffffffff ffffffffffffffff 00000000000000ff 8ee09 8ee09 8ee09 8ee09 8ee09 8ee09 8ee09 8ee09

// File: files.f
conv_pkg.sv
row_window.sv
weight_loader.sv
conv_ctrl.sv
pe_cube.sv
result_reduce.sv
conv_top.sv
tb_conv_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_top -f files.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_conv_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
